/* usbtest_defines.svh */
`ifndef USBTEST_DEFINES_SVH
`define USBTEST_DEFINES_SVH

// words read from the fx3 per burst
`define FX3_BURST_WORDS 16

// cycles from a sampled low slrd_n to valid data on the bus
`define FX3_RD_LATENCY 2

// idle cycles after each burst, all strobes high
`define FX3_COOLDOWN 10

// fifo address width, 32 entries
`define FIFO_ADDR_W 5

// stream-out endpoint on the fx3 a1/a0 pins
`define FX3_EP_OUT_ADDR 2'd3

`endif

/* usbtest_pkg.sv */
package usbtest_pkg;

    // one word on the fx3 bus
    // bits 11..8 red, 7..4 green, 3..0 blue, top nibble unused
    typedef logic [15:0] fx3_word_t;

    // expanded pixel, 8 bits per channel
    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgb_t;

    // slave-fifo read controller states
    typedef enum logic [1:0] {
        // waiting for flags and fifo room
        ST_IDLE     = 2'd0,
        // strobing slrd_n for one burst
        ST_BURST    = 2'd1,
        // waiting for the last word to reach the fifo
        ST_DRAIN    = 2'd2,
        // bus released before the next flag check
        ST_COOLDOWN = 2'd3
    } fx3_state_e;

endpackage

/* fifo_if.sv */
interface fifo_if
    import usbtest_pkg::*;
();

    // write side, usb_clk domain
    fx3_word_t wdata;
    logic      winc;
    logic      wfull;
    logic      walmost_full;

    // read side, pix_clk domain
    fx3_word_t rdata;
    logic      rinc;
    logic      rempty;

    // fx3 controller pushes words
    modport push (output wdata, winc, input wfull, walmost_full);

    // the fifo itself
    modport store (
        input  wdata, winc, rinc,
        output wfull, walmost_full, rdata, rempty
    );

    // pixel stage pops words
    modport pop (output rinc, input rdata, rempty);

endinterface

/* fx3_stream_out.sv */
`include "usbtest_defines.svh"

module fx3_stream_out
    import usbtest_pkg::*;
(
    input  logic      usb_clk,
    input  logic      rst,
    input  logic      flagc_i,
    input  logic      flagd_i,
    input  fx3_word_t data_i,
    output logic      slcs_n_o,
    output logic      sloe_n_o,
    output logic      slrd_n_o,
    output logic [1:0] addr_o,
    fifo_if.push      fifo
);

    localparam int LAT    = `FX3_RD_LATENCY;
    localparam int WORD_W = $clog2(`FX3_BURST_WORDS);
    localparam int COOL_W = $clog2(`FX3_COOLDOWN);

    fx3_state_e        state;
    logic [WORD_W-1:0] word_cnt;
    logic [COOL_W-1:0] cool_cnt;

    // registered fx3 flags
    logic flagc_q;
    logic flagd_q;

    // one bit per outstanding read strobe
    logic [LAT-1:0] rd_pipe;
    logic           rd_strobe;

    // captured bus word and its push strobe
    fx3_word_t data_q;
    logic      winc_q;

    // slrd_n low for every cycle spent in burst
    assign rd_strobe = (state == ST_BURST);

    // strobes are decoded from the state register
    always_comb begin
        slcs_n_o = 1'b1;
        sloe_n_o = 1'b1;
        slrd_n_o = 1'b1;
        addr_o   = 2'd0;
        if (state == ST_BURST || state == ST_DRAIN) begin
            // bus held until the last word is pushed
            slcs_n_o = 1'b0;
            sloe_n_o = 1'b0;
            addr_o   = `FX3_EP_OUT_ADDR;
        end
        if (rd_strobe) begin
            slrd_n_o = 1'b0;
        end
    end

    // bus sampled every cycle, only used when the pipe says so
    always_ff @(posedge usb_clk) begin
        data_q <= data_i;
    end

    always_ff @(posedge usb_clk or negedge rst) begin
        if (!rst) begin
            flagc_q  <= 1'b0;
            flagd_q  <= 1'b0;
            rd_pipe  <= '0;
            winc_q   <= 1'b0;
            state    <= ST_IDLE;
            word_cnt <= '0;
            cool_cnt <= '0;
        end else begin
            flagc_q <= flagc_i;
            flagd_q <= flagd_i;
            // data valid LAT cycles after the strobe
            rd_pipe <= (rd_pipe << 1) | LAT'(rd_strobe);
            // push one cycle after capture
            winc_q  <= rd_pipe[LAT-1];

            case (state)
                ST_IDLE: begin
                    // endpoint ready, data present, room for a whole burst
                    if (flagc_q && flagd_q && !fifo.walmost_full) begin
                        state    <= ST_BURST;
                        word_cnt <= '0;
                    end
                end
                ST_BURST: begin
                    if (word_cnt == WORD_W'(`FX3_BURST_WORDS - 1)) begin
                        state <= ST_DRAIN;
                    end else begin
                        word_cnt <= word_cnt + 1'b1;
                    end
                end
                ST_DRAIN: begin
                    // last push happens on this edge
                    if (winc_q && rd_pipe == '0) begin
                        state    <= ST_COOLDOWN;
                        cool_cnt <= '0;
                    end
                end
                ST_COOLDOWN: begin
                    if (cool_cnt == COOL_W'(`FX3_COOLDOWN - 1)) begin
                        state <= ST_IDLE;
                    end else begin
                        cool_cnt <= cool_cnt + 1'b1;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    assign fifo.wdata = data_q;
    assign fifo.winc  = winc_q;

endmodule

/* async_fifo.sv */
`include "usbtest_defines.svh"

module async_fifo
    import usbtest_pkg::*;
#(
    parameter int ADDR_W = `FIFO_ADDR_W
) (
    input  logic   usb_clk,
    input  logic   pix_clk,
    input  logic   rst,
    fifo_if.store  fifo
);

    localparam int DEPTH = 2 ** ADDR_W;

    fx3_word_t mem [DEPTH];

    // write domain pointers and synced read pointer
    logic [ADDR_W:0] wbin, wgray, wbin_next;
    logic [ADDR_W:0] rq1_gray, rq2_gray, rq2_bin;
    logic [ADDR_W:0] used_w;
    logic            do_write;

    // read domain pointers and synced write pointer
    logic [ADDR_W:0] rbin, rgray, rbin_next, rgray_next;
    logic [ADDR_W:0] wq1_gray, wq2_gray;
    logic            do_read;

    function automatic logic [ADDR_W:0] bin2gray(input logic [ADDR_W:0] b);
        return b ^ (b >> 1);
    endfunction

    function automatic logic [ADDR_W:0] gray2bin(input logic [ADDR_W:0] g);
        logic [ADDR_W:0] b;
        b[ADDR_W] = g[ADDR_W];
        for (int i = ADDR_W - 1; i >= 0; i--) begin
            b[i] = b[i+1] ^ g[i];
        end
        return b;
    endfunction

    // write side
    assign do_write  = fifo.winc && !fifo.wfull;
    assign wbin_next = wbin + (ADDR_W + 1)'(do_write);

    always_ff @(posedge usb_clk) begin
        if (do_write) begin
            mem[wbin[ADDR_W-1:0]] <= fifo.wdata;
        end
    end

    always_ff @(posedge usb_clk or negedge rst) begin
        if (!rst) begin
            wbin     <= '0;
            wgray    <= '0;
            rq1_gray <= '0;
            rq2_gray <= '0;
        end else begin
            wbin     <= wbin_next;
            wgray    <= bin2gray(wbin_next);
            // two-flop sync of the read gray pointer
            rq1_gray <= rgray;
            rq2_gray <= rq1_gray;
        end
    end

    // fill level seen from the write side, pessimistic
    assign rq2_bin           = gray2bin(rq2_gray);
    assign used_w            = wbin - rq2_bin;
    assign fifo.wfull        = used_w[ADDR_W];
    // fewer than one burst of entries left
    assign fifo.walmost_full = used_w > (ADDR_W + 1)'(DEPTH - `FX3_BURST_WORDS);

    // read side
    assign do_read    = fifo.rinc && !fifo.rempty;
    assign rbin_next  = rbin + (ADDR_W + 1)'(do_read);
    assign rgray_next = bin2gray(rbin_next);

    always_ff @(posedge pix_clk or negedge rst) begin
        if (!rst) begin
            rbin        <= '0;
            rgray       <= '0;
            wq1_gray    <= '0;
            wq2_gray    <= '0;
            fifo.rempty <= 1'b1;
        end else begin
            rbin        <= rbin_next;
            rgray       <= rgray_next;
            wq1_gray    <= wgray;
            wq2_gray    <= wq1_gray;
            // registered empty, looks ahead at this cycle's pop
            fifo.rempty <= (rgray_next == wq2_gray);
        end
    end

    // head word, valid while rempty is low
    assign fifo.rdata = mem[rbin[ADDR_W-1:0]];

endmodule

/* pixel_unpack.sv */
module pixel_unpack
    import usbtest_pkg::*;
(
    input  logic  pix_clk,
    input  logic  rst,
    input  logic  fetch_i,
    fifo_if.pop   fifo,
    output rgb_t  pixel_o,
    output logic  pixel_valid_o
);

    logic pop;
    rgb_t expanded;

    // one word per display fetch, only when there is one
    assign pop       = fetch_i && !fifo.rempty;
    assign fifo.rinc = pop;

    // 4-bit fields go to the upper nibble
    always_comb begin
        expanded.red   = {fifo.rdata[11:8], 4'h0};
        expanded.green = {fifo.rdata[7:4], 4'h0};
        expanded.blue  = {fifo.rdata[3:0], 4'h0};
    end

    // pixel payload
    always_ff @(posedge pix_clk) begin
        if (pop) begin
            pixel_o <= expanded;
        end
    end

    // valid the cycle after a pop
    always_ff @(posedge pix_clk or negedge rst) begin
        if (!rst) begin
            pixel_valid_o <= 1'b0;
        end else begin
            pixel_valid_o <= pop;
        end
    end

endmodule

/* usbtest_top.sv */
module usbtest_top
    import usbtest_pkg::*;
(
    input  logic       usb_clk,
    input  logic       pix_clk,
    input  logic       rst,
    input  fx3_word_t  fx3_data_i,
    input  logic       fx3_flagc_i,
    input  logic       fx3_flagd_i,
    input  logic       fetch_i,
    output logic       fx3_slcs_n_o,
    output logic       fx3_sloe_n_o,
    output logic       fx3_slrd_n_o,
    output logic [1:0] fx3_addr_o,
    output logic [7:0] red_o,
    output logic [7:0] green_o,
    output logic [7:0] blue_o,
    output logic       pixel_valid_o
);

    // usb_clk to pix_clk word path
    fifo_if u_fifo_if ();

    rgb_t pixel;

    // slave-fifo master, usb_clk domain
    fx3_stream_out u_fx3_stream_out (
        .usb_clk  (usb_clk),
        .rst      (rst),
        .flagc_i  (fx3_flagc_i),
        .flagd_i  (fx3_flagd_i),
        .data_i   (fx3_data_i),
        .slcs_n_o (fx3_slcs_n_o),
        .sloe_n_o (fx3_sloe_n_o),
        .slrd_n_o (fx3_slrd_n_o),
        .addr_o   (fx3_addr_o),
        .fifo     (u_fifo_if.push)
    );

    async_fifo u_async_fifo (
        .usb_clk (usb_clk),
        .pix_clk (pix_clk),
        .rst     (rst),
        .fifo    (u_fifo_if.store)
    );

    // pix_clk domain
    pixel_unpack u_pixel_unpack (
        .pix_clk       (pix_clk),
        .rst           (rst),
        .fetch_i       (fetch_i),
        .fifo          (u_fifo_if.pop),
        .pixel_o       (pixel),
        .pixel_valid_o (pixel_valid_o)
    );

    // struct onto the colour pins
    assign red_o   = pixel.red;
    assign green_o = pixel.green;
    assign blue_o  = pixel.blue;

endmodule

/* tb_usbtest_assert.sv */
`include "usbtest_defines.svh"

module tb_usbtest_assert
    import usbtest_pkg::*;
(
    input logic       usb_clk,
    input logic       pix_clk,
    input logic       rst,
    input logic       flagc_i,
    input logic       flagd_i,
    input logic       slcs_n_i,
    input logic       sloe_n_i,
    input logic       slrd_n_i,
    input logic [1:0] addr_i,
    input fx3_state_e state_i,
    input logic       fetch_i,
    input logic [7:0] red_i,
    input logic [7:0] green_i,
    input logic [7:0] blue_i,
    input logic       pixel_valid_i
);

    localparam int BURST = `FX3_BURST_WORDS;
    localparam int COOL  = `FX3_COOLDOWN;

    // failures seen per clock domain
    int usb_fails = 0;
    int pix_fails = 0;

    // strobe history, usb_clk domain
    logic       slrd_n_q;
    logic       seen_burst;
    logic [7:0] low_run;
    logic [7:0] high_run;
    logic       flagc_d1, flagc_d2;
    logic       flagd_d1, flagd_d2;

    // scoreboard, pix_clk domain
    logic [11:0] exp_cnt;
    logic        fetch_q;

    // 4-bit fields into the upper nibble of each channel
    function automatic logic [23:0] expand_word(input logic [11:0] w);
        return {w[11:8], 4'h0, w[7:4], 4'h0, w[3:0], 4'h0};
    endfunction

    always_ff @(posedge usb_clk or negedge rst) begin
        if (!rst) begin
            slrd_n_q   <= 1'b1;
            seen_burst <= 1'b0;
            low_run    <= '0;
            high_run   <= '0;
            flagc_d1   <= 1'b0;
            flagc_d2   <= 1'b0;
            flagd_d1   <= 1'b0;
            flagd_d2   <= 1'b0;
        end else begin
            slrd_n_q <= slrd_n_i;
            flagc_d1 <= flagc_i;
            flagc_d2 <= flagc_d1;
            flagd_d1 <= flagd_i;
            flagd_d2 <= flagd_d1;
            if (!slrd_n_i) begin
                low_run    <= low_run + 8'd1;
                high_run   <= '0;
                seen_burst <= 1'b1;
            end else begin
                low_run <= '0;
                // saturates, only the lower bound matters
                if (high_run != 8'hff) begin
                    high_run <= high_run + 8'd1;
                end
            end
        end
    end

    always_ff @(posedge pix_clk or negedge rst) begin
        if (!rst) begin
            exp_cnt <= '0;
            fetch_q <= 1'b0;
        end else begin
            fetch_q <= fetch_i;
            if (pixel_valid_i) begin
                exp_cnt <= exp_cnt + 12'd1;
            end
        end
    end

    // bus released in reset and in idle
    a_idle_strobes: assert property (@(posedge usb_clk)
        (!rst || state_i == ST_IDLE) |-> (slcs_n_i && sloe_n_i && slrd_n_i))
        else begin
            $error("idle_strobes: an fx3 strobe is low in reset or idle");
            usb_fails++;
        end

    a_read_select: assert property (@(posedge usb_clk) disable iff (!rst)
        !slrd_n_i |-> (!slcs_n_i && !sloe_n_i && addr_i == `FX3_EP_OUT_ADDR))
        else begin
            $error("read_select: slrd_n low without chip select, oe or endpoint");
            usb_fails++;
        end

    // rising slrd_n ends a burst
    a_burst_length: assert property (@(posedge usb_clk) disable iff (!rst)
        (slrd_n_i && !slrd_n_q) |-> (low_run == 8'(BURST)))
        else begin
            $error("mismatch test=burst_length expected=%0d actual=%0d",
                   BURST, $sampled(low_run));
            usb_fails++;
        end

    a_burst_gap: assert property (@(posedge usb_clk) disable iff (!rst)
        (!slrd_n_i && slrd_n_q && seen_burst) |-> (high_run >= 8'(COOL)))
        else begin
            $error("burst_gap: next burst began only %0d cycles after the last",
                   $sampled(high_run));
            usb_fails++;
        end

    // flags reach idle through one register stage
    a_flags_before_burst: assert property (@(posedge usb_clk) disable iff (!rst)
        (!slrd_n_i && slrd_n_q) |-> (flagc_d2 && flagd_d2))
        else begin
            $error("flags_before_burst: burst began without both fx3 flags high");
            usb_fails++;
        end

    a_pixel_order: assert property (@(posedge pix_clk) disable iff (!rst)
        pixel_valid_i |-> ({red_i, green_i, blue_i} == expand_word(exp_cnt)))
        else begin
            $error("mismatch test=pixel_order expected=%h actual=%h",
                   expand_word($sampled(exp_cnt)),
                   {$sampled(red_i), $sampled(green_i), $sampled(blue_i)});
            pix_fails++;
        end

    a_valid_after_fetch: assert property (@(posedge pix_clk) disable iff (!rst)
        pixel_valid_i |-> fetch_q)
        else begin
            $error("valid_after_fetch: pixel valid without a fetch the cycle before");
            pix_fails++;
        end

endmodule

/* tb_usbtest.sv */
`include "usbtest_defines.svh"

module tb_usbtest
    import usbtest_pkg::*;
();

    // target pixel count and watchdog limit in time units
    localparam int LAT      = `FX3_RD_LATENCY;
    localparam int PIXELS   = 12 * `FX3_BURST_WORDS;
    localparam int WATCHDOG = 40 * (`FX3_BURST_WORDS + `FX3_COOLDOWN + 10) * 4;

    logic       usb_clk;
    logic       pix_clk;
    logic       rst;
    logic       flagc;
    logic       flagd;
    logic       fetch;
    fx3_word_t  data;
    logic       slcs_n;
    logic       sloe_n;
    logic       slrd_n;
    logic [1:0] addr;
    logic [7:0] red;
    logic [7:0] green;
    logic [7:0] blue;
    logic       pixel_valid;

    // fx3 model read pipe and counters
    logic [LAT-1:0] rd_hist;
    int             word_cnt;
    int             pix_seen;
    int             hold_left;
    int             fails;

    usbtest_top u_dut (
        .usb_clk       (usb_clk),
        .pix_clk       (pix_clk),
        .rst           (rst),
        .fx3_data_i    (data),
        .fx3_flagc_i   (flagc),
        .fx3_flagd_i   (flagd),
        .fetch_i       (fetch),
        .fx3_slcs_n_o  (slcs_n),
        .fx3_sloe_n_o  (sloe_n),
        .fx3_slrd_n_o  (slrd_n),
        .fx3_addr_o    (addr),
        .red_o         (red),
        .green_o       (green),
        .blue_o        (blue),
        .pixel_valid_o (pixel_valid)
    );

    bind usbtest_top tb_usbtest_assert u_assert (
        .usb_clk       (usb_clk),
        .pix_clk       (pix_clk),
        .rst           (rst),
        .flagc_i       (fx3_flagc_i),
        .flagd_i       (fx3_flagd_i),
        .slcs_n_i      (fx3_slcs_n_o),
        .sloe_n_i      (fx3_sloe_n_o),
        .slrd_n_i      (fx3_slrd_n_o),
        .addr_i        (fx3_addr_o),
        .state_i       (u_fx3_stream_out.state),
        .fetch_i       (fetch_i),
        .red_i         (red_o),
        .green_i       (green_o),
        .blue_i        (blue_o),
        .pixel_valid_i (pixel_valid_o)
    );

    // failures counted in both clock domains of the checker
    assign fails = u_dut.u_assert.usb_fails + u_dut.u_assert.pix_fails;

    // usb_clk period 4, pix_clk period 6
    always #2 usb_clk = ~usb_clk;
    always #3 pix_clk = ~pix_clk;

    initial begin
        void'($urandom(32'h9b64));
        usb_clk   = 1'b0;
        pix_clk   = 1'b0;
        rst       = 1'b0;
        flagc     = 1'b0;
        flagd     = 1'b0;
        fetch     = 1'b0;
        data      = '0;
        rd_hist   = '0;
        word_cnt  = 0;
        pix_seen  = 0;
        hold_left = 120;
        // five full usb_clk cycles in reset
        repeat (5) @(posedge usb_clk);
        @(negedge usb_clk);
        rst = 1'b1;
    end

    // fx3 device puts a word on the bus LAT cycles after each sampled strobe
    always @(negedge usb_clk) begin
        if (rst) begin
            if (rd_hist[LAT-1]) begin
                data = {4'h0, word_cnt[11:0]};
                word_cnt++;
            end else begin
                // junk between words that must never be pushed
                data = fx3_word_t'($urandom);
            end
            rd_hist = (rd_hist << 1) | LAT'(!slrd_n);
            // flags high three cycles out of four
            flagc   = ($urandom % 4) != 0;
            flagd   = ($urandom % 4) != 0;
        end
    end

    // stop at the first assertion failure
    always @(negedge usb_clk) begin
        if (fails != 0) begin
            $display("*** FAILED ***");
            $fatal(1, "an assertion in the bound checker failed");
        end
    end

    // display fetch with a stall so the fifo fills up
    always @(negedge pix_clk) begin
        if (rst) begin
            // pixels counted earlier have been checked by now
            if (pix_seen >= PIXELS) begin
                if (fails == 0) begin
                    $display("*** PASSED ***");
                    $finish;
                end else begin
                    $display("*** FAILED ***");
                    $fatal(1, "assertion failures seen before the end of the run");
                end
            end else begin
                if (pixel_valid) begin
                    pix_seen++;
                end
                if (pix_seen >= 2 * `FX3_BURST_WORDS && hold_left > 0) begin
                    // back-pressure phase
                    fetch = 1'b0;
                    hold_left--;
                end else if (hold_left > 0) begin
                    fetch = ($urandom % 2) != 0;
                end else begin
                    fetch = ($urandom % 4) != 0;
                end
            end
        end
    end

    // watchdog sized for 40 bursts
    initial begin
        #(WATCHDOG);
        $display("timeout: only %0d of %0d pixels arrived in %0d time units",
                 pix_seen, PIXELS, WATCHDOG);
        $display("*** FAILED ***");
        $fatal(1, "watchdog expired");
    end

endmodule

/* usbtest.f */
+incdir+.
usbtest_pkg.sv
fifo_if.sv
fx3_stream_out.sv
async_fifo.sv
pixel_unpack.sv
usbtest_top.sv
tb_usbtest_assert.sv
tb_usbtest.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_usbtest
FILELIST  ?= usbtest.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+100
FAIL_MSG  := *** FAILED ***
PASS_MSG  := *** PASSED ***

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS SIM_ARGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then echo "test failed, see $(LOG)"; exit 1; fi
	@if ! grep -qF '$(PASS_MSG)' $(LOG); then echo "run did not complete"; exit 1; fi
	@echo "test passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
